/* design/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    // data word width seen by the core
    parameter int xlen = 32;

    // reorder buffer tag
    typedef logic [4:0] rob_tag_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    // packet from issue, one memory op per cycle
    typedef struct packed {
        logic             valid;
        logic             rd_mem;
        logic             wr_mem;
        logic             rd_unsigned;
        mem_size_e        mem_size;
        rob_tag_t         rob_tag;
        // producer of the store data when not yet known
        rob_tag_t         store_data_tag;
        logic             store_data_valid;
        logic [xlen-1:0]  store_data;
    } lsq_dispatch_t;

    // effective address from execute, matched by rob tag
    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        logic [xlen-1:0]  addr;
    } lsq_addr_t;

    // common data bus packet, both directions
    typedef struct packed {
        logic             valid;
        rob_tag_t         rob_tag;
        logic [xlen-1:0]  value;
    } cdb_t;

    // one slot of the load/store queue
    typedef struct packed {
        logic             valid;
        logic             is_store;
        // store may go to the cache once set
        logic             retired;
        logic             rd_unsigned;
        mem_size_e        mem_size;
        rob_tag_t         rob_tag;
        logic             address_valid;
        logic [xlen-1:0]  address;
        rob_tag_t         store_data_tag;
        logic             store_data_valid;
        logic [xlen-1:0]  store_data;
    } lsq_entry_t;

endpackage

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // cache transaction tag, zero means no transaction
    typedef logic [3:0] dc_tag_t;

    localparam dc_tag_t dc_tag_none = 4'd0;

    // bus command toward the data cache
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    // request side, held stable until accepted
    typedef struct packed {
        bus_cmd_e     command;
        logic [31:0]  addr;
        // store data sits in the low half
        logic [63:0]  data;
    } dcache_req_t;

    // answer side
    typedef struct packed {
        // nonzero when the request is accepted this cycle
        dc_tag_t      response;
        logic         hit;
        // nonzero when an earlier miss comes back
        dc_tag_t      return_tag;
        logic [63:0]  data;
    } dcache_rsp_t;

endpackage

`default_nettype wire

/* design/lsq_queue_pointers.sv */
`default_nettype none

module lsq_queue_pointers #(
    parameter int lsq_size = 8,
    localparam int idx_w = $clog2(lsq_size)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              dispatch_mem_op,
    input  logic              pop,
    output logic [idx_w-1:0]  head_idx,
    output logic [idx_w-1:0]  tail_idx,
    output logic              push,
    output logic              lsq_free
);

    logic [idx_w-1:0] head_next;
    logic [idx_w-1:0] tail_next;
    logic             full;

    // circular increment, also covers sizes that are not a power of two
    function automatic logic [idx_w-1:0] ptr_incr(input logic [idx_w-1:0] ptr);
        logic [idx_w-1:0] result;
        if (ptr == idx_w'(lsq_size - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign head_next = ptr_incr(head_idx);
    assign tail_next = ptr_incr(tail_idx);

    // one slot stays empty so full and empty differ
    assign full     = (tail_next == head_idx);
    assign lsq_free = !full;
    assign push     = dispatch_mem_op && !full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_idx <= '0;
            tail_idx <= '0;
        end else begin
            if (push) begin
                tail_idx <= tail_next;
            end
            // head only moves on a completed cache op
            if (pop) begin
                head_idx <= head_next;
            end
        end
    end

endmodule

`default_nettype wire

/* design/lsq_head_fsm.sv */
`default_nettype none

module lsq_head_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  lsq_pkg::lsq_entry_t       head_entry,
    input  dcache_pkg::dcache_rsp_t   dcache_rsp,
    output dcache_pkg::dcache_req_t   dcache_req,
    output logic                      pop,
    output logic                      hit_done,
    output logic                      miss_issue,
    output logic                      miss_done
);

    import lsq_pkg::*;
    import dcache_pkg::*;

    typedef enum logic {
        st_idle      = 1'b0,
        st_miss_wait = 1'b1
    } state_e;

    state_e  state;
    dc_tag_t miss_tag;
    logic    head_ready;
    logic    issue;
    logic    accepted;
    logic    load_accepted;
    logic    miss_return;

    // loads need only an address, stores also need data and retirement
    assign head_ready = head_entry.valid && head_entry.address_valid
                     && (!head_entry.is_store
                         || (head_entry.store_data_valid && head_entry.retired));

    // blocking cache, nothing goes out while a miss is pending
    assign issue = (state == st_idle) && head_ready;

    always_comb begin
        dcache_req.command = bus_none;
        dcache_req.addr    = '0;
        dcache_req.data    = '0;
        if (issue) begin
            dcache_req.command = head_entry.is_store ? bus_store : bus_load;
            dcache_req.addr    = head_entry.address;
            if (head_entry.is_store) begin
                dcache_req.data = {{(64 - xlen){1'b0}}, head_entry.store_data};
            end
        end
    end

    // zero response is back-pressure, request repeats next cycle
    assign accepted      = issue && (dcache_rsp.response != dc_tag_none);
    assign load_accepted = accepted && !head_entry.is_store;
    assign miss_return   = (state == st_miss_wait)
                        && (dcache_rsp.return_tag != dc_tag_none)
                        && (dcache_rsp.return_tag == miss_tag);

    assign hit_done   = load_accepted && dcache_rsp.hit;
    assign miss_issue = load_accepted && !dcache_rsp.hit;
    assign miss_done  = miss_return;
    // stores retire from the queue as soon as the cache takes them
    assign pop = (accepted && (head_entry.is_store || dcache_rsp.hit)) || miss_return;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            miss_tag <= dc_tag_none;
        end else begin
            if (miss_issue) begin
                state    <= st_miss_wait;
                miss_tag <= dcache_rsp.response;
            end else if (miss_return) begin
                state    <= st_idle;
                miss_tag <= dc_tag_none;
            end
        end
    end

endmodule

`default_nettype wire

/* design/lsq_entry_array.sv */
`default_nettype none

module lsq_entry_array #(
    parameter int lsq_size = 8,
    localparam int idx_w = $clog2(lsq_size)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  lsq_pkg::lsq_dispatch_t  dispatch,
    output logic                    dispatch_mem_op,
    input  logic                    push,
    input  logic                    pop,
    input  logic [idx_w-1:0]        head_idx,
    input  logic [idx_w-1:0]        tail_idx,
    input  lsq_pkg::lsq_addr_t      addr_in,
    input  lsq_pkg::cdb_t           cdb_in,
    input  logic                    retire_valid,
    input  lsq_pkg::rob_tag_t       retire_tag,
    output lsq_pkg::lsq_entry_t     head_entry
);

    import lsq_pkg::*;

    lsq_entry_t entries [lsq_size];
    lsq_entry_t fresh_entry;

    // only loads and stores take a slot
    assign dispatch_mem_op = dispatch.valid && (dispatch.rd_mem || dispatch.wr_mem);

    // new entry, address still unknown
    always_comb begin
        fresh_entry.valid            = 1'b1;
        fresh_entry.is_store         = dispatch.wr_mem;
        fresh_entry.retired          = 1'b0;
        fresh_entry.rd_unsigned      = dispatch.rd_unsigned;
        fresh_entry.mem_size         = dispatch.mem_size;
        fresh_entry.rob_tag          = dispatch.rob_tag;
        fresh_entry.address_valid    = 1'b0;
        fresh_entry.address          = '0;
        fresh_entry.store_data_tag   = dispatch.store_data_tag;
        fresh_entry.store_data_valid = dispatch.store_data_valid;
        fresh_entry.store_data       = dispatch.store_data;
    end

    assign head_entry = entries[head_idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < lsq_size; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lsq_size; i++) begin
                // address from execute, first match wins the slot
                if (addr_in.valid && entries[i].valid && !entries[i].address_valid
                    && (entries[i].rob_tag == addr_in.tag)) begin
                    entries[i].address       <= addr_in.addr;
                    entries[i].address_valid <= 1'b1;
                end
                // store data snooped from the cdb
                if (cdb_in.valid && entries[i].valid && entries[i].is_store
                    && !entries[i].store_data_valid
                    && (entries[i].store_data_tag == cdb_in.rob_tag)) begin
                    entries[i].store_data       <= cdb_in.value;
                    entries[i].store_data_valid <= 1'b1;
                end
                // rob lets the store go to memory
                if (retire_valid && entries[i].valid && entries[i].is_store
                    && (entries[i].rob_tag == retire_tag)) begin
                    entries[i].retired <= 1'b1;
                end
            end

            // tail slot is always free when push is set
            if (push) begin
                entries[tail_idx] <= fresh_entry;
            end

            if (pop) begin
                entries[head_idx].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/load_data_formatter.sv */
`default_nettype none

module load_data_formatter (
    input  logic                 clk,
    input  logic                 reset,
    input  lsq_pkg::lsq_entry_t  head_entry,
    input  logic [63:0]          dcache_data,
    input  logic                 hit_done,
    input  logic                 miss_issue,
    input  logic                 miss_done,
    output lsq_pkg::cdb_t        cdb_out
);

    import lsq_pkg::*;

    // load details kept while the miss is outstanding
    logic             miss_upper;
    mem_size_e        miss_size;
    logic             miss_unsigned;
    rob_tag_t         miss_tag;

    logic             sel_upper;
    mem_size_e        sel_size;
    logic             sel_unsigned;
    rob_tag_t         sel_tag;
    logic [xlen-1:0]  raw_word;
    logic [xlen-1:0]  ext_word;

    always_ff @(posedge clk) begin
        if (miss_issue) begin
            miss_upper    <= head_entry.address[2];
            miss_size     <= head_entry.mem_size;
            miss_unsigned <= head_entry.rd_unsigned;
            miss_tag      <= head_entry.rob_tag;
        end
    end

    // hit uses the live head, miss the latched copy
    assign sel_upper    = hit_done ? head_entry.address[2]  : miss_upper;
    assign sel_size     = hit_done ? head_entry.mem_size    : miss_size;
    assign sel_unsigned = hit_done ? head_entry.rd_unsigned : miss_unsigned;
    assign sel_tag      = hit_done ? head_entry.rob_tag     : miss_tag;

    // address bit 2 picks the word inside the 64-bit line
    assign raw_word = sel_upper ? dcache_data[63:32] : dcache_data[31:0];

    always_comb begin
        case (sel_size)
            mem_byte: begin
                ext_word = {{(xlen - 8){!sel_unsigned && raw_word[7]}}, raw_word[7:0]};
            end
            mem_half: begin
                ext_word = {{(xlen - 16){!sel_unsigned && raw_word[15]}}, raw_word[15:0]};
            end
            default: begin
                ext_word = raw_word;
            end
        endcase
    end

    // one-cycle broadcast after either kind of completion
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cdb_out <= '0;
        end else begin
            cdb_out.valid <= hit_done || miss_done;
            if (hit_done || miss_done) begin
                cdb_out.rob_tag <= sel_tag;
                cdb_out.value   <= ext_word;
            end
        end
    end

endmodule

`default_nettype wire

/* design/lsq.sv */
`default_nettype none

module lsq #(
    parameter int lsq_size = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  lsq_pkg::lsq_dispatch_t    dispatch,
    input  lsq_pkg::lsq_addr_t        addr_in,
    input  lsq_pkg::cdb_t             cdb_in,
    input  logic                      retire_valid,
    input  lsq_pkg::rob_tag_t         retire_tag,
    input  dcache_pkg::dcache_rsp_t   dcache_rsp,
    output dcache_pkg::dcache_req_t   dcache_req,
    output lsq_pkg::cdb_t             cdb_out,
    output logic                      lsq_free
);

    import lsq_pkg::*;

    localparam int idx_w = $clog2(lsq_size);

    logic [idx_w-1:0] head_idx;
    logic [idx_w-1:0] tail_idx;
    logic             dispatch_mem_op;
    logic             push;
    logic             pop;
    logic             hit_done;
    logic             miss_issue;
    logic             miss_done;
    lsq_entry_t       head_entry;

    lsq_queue_pointers #(
        .lsq_size (lsq_size)
    ) i_pointers (
        .clk             (clk),
        .reset           (reset),
        .dispatch_mem_op (dispatch_mem_op),
        .pop             (pop),
        .head_idx        (head_idx),
        .tail_idx        (tail_idx),
        .push            (push),
        .lsq_free        (lsq_free)
    );

    lsq_entry_array #(
        .lsq_size (lsq_size)
    ) i_entries (
        .clk             (clk),
        .reset           (reset),
        .dispatch        (dispatch),
        .dispatch_mem_op (dispatch_mem_op),
        .push            (push),
        .pop             (pop),
        .head_idx        (head_idx),
        .tail_idx        (tail_idx),
        .addr_in         (addr_in),
        .cdb_in          (cdb_in),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .head_entry      (head_entry)
    );

    lsq_head_fsm i_head_fsm (
        .clk        (clk),
        .reset      (reset),
        .head_entry (head_entry),
        .dcache_rsp (dcache_rsp),
        .dcache_req (dcache_req),
        .pop        (pop),
        .hit_done   (hit_done),
        .miss_issue (miss_issue),
        .miss_done  (miss_done)
    );

    load_data_formatter i_formatter (
        .clk         (clk),
        .reset       (reset),
        .head_entry  (head_entry),
        .dcache_data (dcache_rsp.data),
        .hit_done    (hit_done),
        .miss_issue  (miss_issue),
        .miss_done   (miss_done),
        .cdb_out     (cdb_out)
    );

endmodule

`default_nettype wire

/* tb/dcache_model.sv */
`default_nettype none

module dcache_model (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              rand_word,
    input  dcache_pkg::dcache_req_t  req,
    output dcache_pkg::dcache_rsp_t  rsp,
    output int                       store_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    logic         pend_valid;
    dc_tag_t      pend_tag;
    logic [2:0]   pend_cnt;
    logic [31:0]  pend_addr;
    dc_tag_t      next_tag;
    logic         accept;
    logic         is_hit;
    logic         ret_active;

    // memory contents, one 64-bit line per 8-byte address
    function automatic logic [63:0] line_data(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:3], 3'b000};
        return {(a * 32'h9e3779b1) ^ 32'h13572468, ~a ^ {a[15:0], a[31:16]}};
    endfunction

    // top bits pick stall, miss or hit for the request in this cycle
    assign accept     = (req.command != bus_none) && (rand_word[31:30] != 2'd0);
    assign is_hit     = (req.command == bus_store) || !rand_word[29];
    assign ret_active = pend_valid && (pend_cnt == 3'd0);

    always_comb begin
        rsp = '0;
        // miss data comes back on its own tag
        if (ret_active) begin
            rsp.return_tag = pend_tag;
            rsp.data       = line_data(pend_addr);
        end
        if (accept) begin
            rsp.response = next_tag;
            rsp.hit      = is_hit;
            if (req.command == bus_load && is_hit) begin
                rsp.data = line_data(req.addr);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pend_valid  <= 1'b0;
            pend_tag    <= '0;
            pend_cnt    <= '0;
            pend_addr   <= '0;
            next_tag    <= 4'd1;
            store_count <= 0;
        end else begin
            if (ret_active) begin
                pend_valid <= 1'b0;
            end else if (pend_valid) begin
                pend_cnt <= pend_cnt - 3'd1;
            end
            if (accept) begin
                // tags cycle through 1..15, zero is reserved
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                if (req.command == bus_load && !is_hit) begin
                    pend_valid <= 1'b1;
                    pend_tag   <= next_tag;
                    pend_addr  <= req.addr;
                    // return 1 to 6 cycles later
                    pend_cnt   <= 3'(rand_word[18:16] % 3'd6);
                end
                if (req.command == bus_store) begin
                    store_count <= store_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/lsq_tb.sv */
`default_nettype none

module lsq_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import lsq_pkg::*;
    import dcache_pkg::*;

    localparam int lsq_size = 8;
    localparam int max_ops  = 96;

    typedef struct packed {
        logic         is_store;
        logic         rd_unsigned;
        mem_size_e    size;
        rob_tag_t     tag;
        logic         data_early;
        logic [31:0]  addr;
        logic [31:0]  data;
    } op_t;

    logic           clk;
    logic           reset;
    lsq_dispatch_t  dispatch;
    lsq_addr_t      addr_in;
    cdb_t           cdb_in;
    logic           retire_valid;
    rob_tag_t       retire_tag;
    dcache_rsp_t    dcache_rsp;
    dcache_req_t    dcache_req;
    cdb_t           cdb_out;
    logic           lsq_free;
    logic [31:0]    rand_word;
    int             store_count;

    op_t            ops [max_ops];
    logic           addr_sent [max_ops];
    logic           data_sent [max_ops];
    logic           retire_sent [max_ops];
    int             n_ops;
    int             n_dispatched;
    int             n_loads;
    int             n_stores;
    logic [31:0]    seed;
    int             mismatches;
    int             failures;
    int             cycles;

    // scoreboard state
    int             cmd_ptr;
    int             loads_seen;
    logic           miss_pending;
    dc_tag_t        miss_tag;
    int             miss_op;
    logic           bcast_pend;
    rob_tag_t       bcast_tag;
    logic [31:0]    bcast_val;
    logic           prev_refused;
    dcache_req_t    prev_req;
    dcache_req_t    exp_req;
    logic           store_ready_ok;
    logic           accepted;

    lsq #(
        .lsq_size (lsq_size)
    ) i_lsq (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .addr_in      (addr_in),
        .cdb_in       (cdb_in),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag),
        .dcache_rsp   (dcache_rsp),
        .dcache_req   (dcache_req),
        .cdb_out      (cdb_out),
        .lsq_free     (lsq_free)
    );

    dcache_model i_dcache (
        .clk         (clk),
        .reset       (reset),
        .rand_word   (rand_word),
        .req         (dcache_req),
        .rsp         (dcache_rsp),
        .store_count (store_count)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 32-bit half picked by address bit 2, then sized and extended
    function automatic logic [31:0] expect_value(input logic [63:0] line, input op_t op);
        logic [31:0] half;
        half = op.addr[2] ? line[63:32] : line[31:0];
        case (op.size)
            mem_byte: return op.rd_unsigned ? {24'b0, half[7:0]} : {{24{half[7]}}, half[7:0]};
            mem_half: return op.rd_unsigned ? {16'b0, half[15:0]}
                                            : {{16{half[15]}}, half[15:0]};
            default:  return half;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    // cache model randomness has its own stream
    always_ff @(posedge clk) begin
        if (reset) begin
            rand_word <= 32'hde6a381d ^ 32'h5bd1e995;
        end else begin
            rand_word <= lcg_step(rand_word);
        end
    end

    always_comb begin
        exp_req        = '0;
        store_ready_ok = 1'b0;
        if (cmd_ptr < n_ops) begin
            exp_req.command = ops[cmd_ptr].is_store ? bus_store : bus_load;
            exp_req.addr    = ops[cmd_ptr].addr;
            exp_req.data    = ops[cmd_ptr].is_store ? {32'b0, ops[cmd_ptr].data} : 64'b0;
            store_ready_ok  = addr_sent[cmd_ptr] && data_sent[cmd_ptr] && retire_sent[cmd_ptr];
        end
    end

    assign accepted = (dcache_req.command != bus_none) && (dcache_rsp.response != dc_tag_none);

    // predicts the next broadcast from accepted commands and returns
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_ptr      <= 0;
            loads_seen   <= 0;
            miss_pending <= 1'b0;
            bcast_pend   <= 1'b0;
            prev_refused <= 1'b0;
        end else begin
            bcast_pend   <= 1'b0;
            prev_refused <= (dcache_req.command != bus_none) && !accepted;
            prev_req     <= dcache_req;
            if (cdb_out.valid) begin
                loads_seen <= loads_seen + 1;
            end
            if (accepted) begin
                cmd_ptr <= cmd_ptr + 1;
                if (dcache_req.command == bus_load && dcache_rsp.hit) begin
                    bcast_pend <= 1'b1;
                    bcast_tag  <= ops[cmd_ptr].tag;
                    bcast_val  <= expect_value(dcache_rsp.data, ops[cmd_ptr]);
                end else if (dcache_req.command == bus_load) begin
                    miss_pending <= 1'b1;
                    miss_tag     <= dcache_rsp.response;
                    miss_op      <= cmd_ptr;
                end
            end
            if (miss_pending && dcache_rsp.return_tag == miss_tag) begin
                miss_pending <= 1'b0;
                bcast_pend   <= 1'b1;
                bcast_tag    <= ops[miss_op].tag;
                bcast_val    <= expect_value(dcache_rsp.data, ops[miss_op]);
            end
        end
    end

    a_cmd_order: assert property (@(posedge clk) disable iff (reset)
        (dcache_req.command != bus_none) |-> (dcache_req == exp_req))
    else begin
        mismatches++;
        $display("MISMATCH %0t dcache_req exp=%h got=%h", $time, $sampled(exp_req),
                 $sampled(dcache_req));
    end

    a_store_ready: assert property (@(posedge clk) disable iff (reset)
        (dcache_req.command == bus_store) |-> store_ready_ok)
    else begin
        failures++;
        $display("%0t store commanded before address, data and retirement", $time);
    end

    a_blocking: assert property (@(posedge clk) disable iff (reset)
        miss_pending |-> (dcache_req.command == bus_none))
    else begin
        failures++;
        $display("%0t command issued while a miss is outstanding", $time);
    end

    a_repeat: assert property (@(posedge clk) disable iff (reset)
        prev_refused |-> (dcache_req == prev_req))
    else begin
        mismatches++;
        $display("MISMATCH %0t dcache_req after refusal exp=%h got=%h", $time,
                 $sampled(prev_req), $sampled(dcache_req));
    end

    a_cdb_valid: assert property (@(posedge clk) disable iff (reset)
        cdb_out.valid == bcast_pend)
    else begin
        mismatches++;
        $display("MISMATCH %0t cdb_out.valid exp=%b got=%b", $time,
                 $sampled(bcast_pend), $sampled(cdb_out.valid));
    end

    a_cdb_value: assert property (@(posedge clk) disable iff (reset)
        cdb_out.valid |-> (cdb_out.rob_tag == bcast_tag && cdb_out.value == bcast_val))
    else begin
        mismatches++;
        $display("MISMATCH %0t cdb_out exp=%h/%h got=%h/%h", $time, $sampled(bcast_tag),
                 $sampled(bcast_val), $sampled(cdb_out.rob_tag), $sampled(cdb_out.value));
    end

    // run limit grows with every dispatched operation
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * n_dispatched + 200) begin
            $display("timeout after %0d cycles, %0d of %0d commands seen", cycles,
                     cmd_ptr, n_ops);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        seed = lcg_step(seed);
        return seed;
    endfunction

    function automatic op_t make_op(input rob_tag_t tag);
        op_t op;
        logic [31:0] r;
        r              = rand32();
        op.is_store    = (r[31:28] < 4'd6);
        op.rd_unsigned = r[27];
        op.size        = mem_size_e'(r[26:24] % 3'd3);
        op.data_early  = r[23];
        op.tag         = tag;
        op.addr        = rand32();
        op.data        = rand32();
        // keep halves and words naturally aligned
        if (op.size == mem_half) op.addr[0] = 1'b0;
        if (op.size == mem_word) op.addr[1:0] = 2'b00;
        return op;
    endfunction

    function automatic lsq_dispatch_t dispatch_pkt(input op_t op);
        lsq_dispatch_t d;
        d                  = '0;
        d.valid            = 1'b1;
        d.rd_mem           = !op.is_store;
        d.wr_mem           = op.is_store;
        d.rd_unsigned      = op.rd_unsigned;
        d.mem_size         = op.size;
        d.rob_tag          = op.tag;
        d.store_data_tag   = op.tag ^ 5'h10;
        d.store_data_valid = op.is_store && op.data_early;
        d.store_data       = op.data_early ? op.data : 32'b0;
        return d;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_addr(input rob_tag_t tag, input logic [31:0] addr);
        @(posedge clk);
        addr_in <= '{valid: 1'b1, tag: tag, addr: addr};
        @(posedge clk);
        addr_in <= '0;
    endtask

    // late store data on the cdb, flagged once the queue has seen it
    task automatic broadcast_store_data(input int first);
        for (int i = first; i < n_ops; i++) begin
            if (!data_sent[i]) begin
                @(posedge clk);
                cdb_in <= '{valid: 1'b1, rob_tag: ops[i].tag ^ 5'h10, value: ops[i].data};
                @(posedge clk);
                cdb_in <= '0;
                data_sent[i] = 1'b1;
            end
        end
    endtask

    task automatic supply_addresses(input int first);
        for (int i = first; i < n_ops; i++) begin
            idle_cycles(int'(rand32() >> 30));
            send_addr(ops[i].tag, ops[i].addr);
            addr_sent[i] = 1'b1;
        end
    endtask

    task automatic retire_stores(input int first);
        for (int i = first; i < n_ops; i++) begin
            if (!retire_sent[i]) begin
                @(posedge clk);
                retire_valid <= 1'b1;
                retire_tag   <= ops[i].tag;
                @(posedge clk);
                retire_valid <= 1'b0;
                retire_sent[i] = 1'b1;
            end
        end
    endtask

    // one group of operations, the first fills the queue and tries one more
    // order picks which of retirement, data or address comes last
    task automatic run_batch(input int count, input bit fill, input int base, input int order);
        int first;
        op_t op;
        first = n_ops;
        for (int j = 0; j < count; j++) begin
            op = make_op(rob_tag_t'(base + j));
            ops[n_ops]         = op;
            addr_sent[n_ops]   = 1'b0;
            data_sent[n_ops]   = !op.is_store || op.data_early;
            retire_sent[n_ops] = !op.is_store;
            n_loads  += op.is_store ? 0 : 1;
            n_stores += op.is_store ? 1 : 0;
            @(posedge clk);
            dispatch <= dispatch_pkt(op);
            n_ops++;
            n_dispatched++;
        end
        @(posedge clk);
        dispatch <= '0;
        if (fill) begin
            @(posedge clk);
            a_full: assert (!lsq_free) else begin
                mismatches++;
                $display("MISMATCH %0t lsq_free exp=0 got=%b", $time, lsq_free);
            end
            // dropped op, never in the scoreboard
            dispatch <= dispatch_pkt(make_op(rob_tag_t'(base + 7)));
            n_dispatched++;
            @(posedge clk);
            dispatch <= '0;
            send_addr(rob_tag_t'(base + 7), 32'h0000_1000);
        end
        case (order)
            0: begin
                broadcast_store_data(first);
                supply_addresses(first);
                retire_stores(first);
            end
            1: begin
                supply_addresses(first);
                retire_stores(first);
                broadcast_store_data(first);
            end
            default: begin
                retire_stores(first);
                broadcast_store_data(first);
                supply_addresses(first);
            end
        endcase
        while (cmd_ptr < n_ops || miss_pending || bcast_pend) @(posedge clk);
    endtask

    initial begin
        seed         = 32'hde6a381d;
        n_ops        = 0;
        n_dispatched = 0;
        n_loads      = 0;
        n_stores     = 0;
        mismatches   = 0;
        failures     = 0;
        cycles       = 0;
        reset        = 1'b1;
        dispatch     = '0;
        addr_in      = '0;
        cdb_in       = '0;
        retire_valid = 1'b0;
        retire_tag   = '0;
        idle_cycles(2);
        reset <= 1'b0;
        @(posedge clk);
        a_reset: assert (!cdb_out.valid && dcache_req.command == bus_none && lsq_free)
        else begin
            mismatches++;
            $display("MISMATCH %0t reset state exp=0/none/1 got=%b/%0d/%b", $time,
                     cdb_out.valid, dcache_req.command, lsq_free);
        end
        run_batch(lsq_size - 1, 1'b1, 0, 0);
        for (int b = 1; b < 12; b++) begin
            run_batch(1 + int'((rand32() >> 16) % 7), 1'b0, (b % 4) * 8, b % 3);
        end
        idle_cycles(10);
        if (loads_seen != n_loads) begin
            failures++;
            $display("%0d broadcasts seen for %0d loads", loads_seen, n_loads);
        end
        if (store_count != n_stores) begin
            failures++;
            $display("cache took %0d stores, %0d were dispatched", store_count, n_stores);
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/lsq_pkg.sv
design/dcache_pkg.sv
design/lsq_queue_pointers.sv
design/lsq_head_fsm.sv
design/lsq_entry_array.sv
design/load_data_formatter.sv
design/lsq.sv
tb/dcache_model.sv
tb/lsq_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := lsq_tb
RTL_TOP    := lsq
FILE_LIST  := files.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^TEST PASS$$'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
